//--- verilog/md_defines.svh
////////////////////////////////////////////////////////////
// Width macros for the multiply/divide datapath
// Operand width, bit counter width, function code width
////////////////////////////////////////////////////////////
`ifndef MD_DEFINES_SVH
`define MD_DEFINES_SVH

// Operand and result width
`define MD_WIDTH 32

// One count per operand bit
`define MD_CNT_WIDTH 5

// Width of the M extension funct3 field
`define MD_FUNCT_WIDTH 3

`endif

//--- verilog/md_pkg.sv
////////////////////////////////////////////////////////////
// Shared types of the multiply/divide unit
// Operation class, signed mode, function codes, bit counter
////////////////////////////////////////////////////////////
`include "md_defines.svh"

package md_pkg;

  // Which word of which operation the core produces
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Bit 0 marks operand A signed, bit 1 operand B
  typedef logic [1:0] md_sign_t;

  typedef logic [`MD_CNT_WIDTH-1:0] md_cnt_t;

  // Function codes in RISC-V funct3 order
  typedef logic [`MD_FUNCT_WIDTH-1:0] md_funct_t;

  localparam md_funct_t MD_FUNCT_MUL    = 3'd0;
  localparam md_funct_t MD_FUNCT_MULH   = 3'd1;
  localparam md_funct_t MD_FUNCT_MULHSU = 3'd2;
  localparam md_funct_t MD_FUNCT_MULHU  = 3'd3;
  localparam md_funct_t MD_FUNCT_DIV    = 3'd4;
  localparam md_funct_t MD_FUNCT_DIVU   = 3'd5;
  localparam md_funct_t MD_FUNCT_REM    = 3'd6;
  localparam md_funct_t MD_FUNCT_REMU   = 3'd7;

endpackage

//--- verilog/md_adder.sv
////////////////////////////////////////////////////////////
// Shared operand adder of the multiply/divide unit
// Extended sum, sum without the carry-in bit, zero flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "md_defines.svh"

module md_adder (
  input  logic [`MD_WIDTH:0]   operand_a_i,
  input  logic [`MD_WIDTH:0]   operand_b_i,
  output logic [`MD_WIDTH+1:0] sum_ext_o,
  output logic [`MD_WIDTH-1:0] sum_o,
  output logic                 sum_zero_o
);

  // Both operands carry a low bit used as carry-in.
  // Setting both low bits to 1 adds one into bit 1,
  // so {a,1} + {~b,1} gives a - b in the upper bits
  always_comb begin
    sum_ext_o = {1'b0, operand_a_i} + {1'b0, operand_b_i};
  end

  // Drop the carry-in position
  assign sum_o = sum_ext_o[`MD_WIDTH:1];

  // Flags a zero divisor while the core negates B
  assign sum_zero_o = (sum_o == {`MD_WIDTH{1'b0}});

endmodule

//--- verilog/md_issue.sv
////////////////////////////////////////////////////////////
// Issue stage of the multiply/divide unit
// Function decode, operand latch, enable control and
// result register with done pulse
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "md_defines.svh"

module md_issue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  md_pkg::md_funct_t    funct_i,
  input  logic [`MD_WIDTH-1:0] op_a_i,
  input  logic [`MD_WIDTH-1:0] op_b_i,
  output logic                 mult_en_o,
  output logic                 div_en_o,
  output md_pkg::md_op_e       operator_o,
  output md_pkg::md_sign_t     signed_mode_o,
  output logic [`MD_WIDTH-1:0] md_op_a_o,
  output logic [`MD_WIDTH-1:0] md_op_b_o,
  input  logic                 md_ready_i,
  input  logic [`MD_WIDTH-1:0] md_result_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic [`MD_WIDTH-1:0] result_o
);

  md_pkg::md_op_e   op_dec;
  md_pkg::md_sign_t sign_dec;
  logic             is_div;
  logic             accept;

  // Upper funct3 bit selects the divide group
  assign is_div = funct_i[`MD_FUNCT_WIDTH-1];

  always_comb begin
    op_dec   = md_pkg::MD_OP_MULL;
    sign_dec = 2'b00;
    case (funct_i)
      md_pkg::MD_FUNCT_MULH: begin
        op_dec   = md_pkg::MD_OP_MULH;
        sign_dec = 2'b11;
      end
      md_pkg::MD_FUNCT_MULHSU: begin
        op_dec   = md_pkg::MD_OP_MULH;
        sign_dec = 2'b01;
      end
      md_pkg::MD_FUNCT_MULHU: op_dec = md_pkg::MD_OP_MULH;
      md_pkg::MD_FUNCT_DIV: begin
        op_dec   = md_pkg::MD_OP_DIV;
        sign_dec = 2'b11;
      end
      md_pkg::MD_FUNCT_DIVU: op_dec = md_pkg::MD_OP_DIV;
      md_pkg::MD_FUNCT_REM: begin
        op_dec   = md_pkg::MD_OP_REM;
        sign_dec = 2'b11;
      end
      md_pkg::MD_FUNCT_REMU: op_dec = md_pkg::MD_OP_REM;
      // MUL low word does not depend on operand signs
      default: op_dec = md_pkg::MD_OP_MULL;
    endcase
  end

  // Starts while busy are dropped
  assign busy_o = mult_en_o | div_en_o;
  assign accept = start_i & ~busy_o;

  ////////////////////////////////////////////////////////////
  // Control and result
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_en_o     <= 1'b0;
      div_en_o      <= 1'b0;
      done_o        <= 1'b0;
      result_o      <= '0;
      operator_o    <= md_pkg::MD_OP_MULL;
      signed_mode_o <= 2'b00;
    end else begin
      done_o <= md_ready_i;
      if (md_ready_i) begin
        mult_en_o <= 1'b0;
        div_en_o  <= 1'b0;
        result_o  <= md_result_i;
      end else if (accept) begin
        mult_en_o     <= ~is_div;
        div_en_o      <= is_div;
        operator_o    <= op_dec;
        signed_mode_o <= sign_dec;
      end
    end
  end

  // Operand latch
  always_ff @(posedge clk_i) begin
    if (accept) begin
      md_op_a_o <= op_a_i;
      md_op_b_o <= op_b_i;
    end
  end

endmodule

//--- verilog/md_slow.sv
////////////////////////////////////////////////////////////
// Iterative multiply/divide core
// Baugh-Wooley shift-add multiply, restoring long division,
// one bit per cycle through the shared adder
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "md_defines.svh"

module md_slow (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mult_en_i,
  input  logic                 div_en_i,
  input  md_pkg::md_op_e       operator_i,
  input  md_pkg::md_sign_t     signed_mode_i,
  input  logic [`MD_WIDTH-1:0] op_a_i,
  input  logic [`MD_WIDTH-1:0] op_b_i,
  input  logic [`MD_WIDTH+1:0] adder_ext_i,
  input  logic [`MD_WIDTH-1:0] adder_i,
  input  logic                 adder_zero_i,
  output logic [`MD_WIDTH:0]   alu_operand_a_o,
  output logic [`MD_WIDTH:0]   alu_operand_b_o,
  output logic [`MD_WIDTH-1:0] result_o,
  output logic                 ready_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ABS_A,
    ST_ABS_B,
    ST_COMP,
    ST_LAST,
    ST_CHSIGN,
    ST_FINISH
  } state_e;

  state_e          state_q, state_d;
  md_pkg::md_cnt_t cnt_q, cnt_d, cnt_m1;

  logic [`MD_WIDTH:0]   accum_q, accum_d;
  logic [`MD_WIDTH:0]   op_a_shift_q, op_a_shift_d;
  logic [`MD_WIDTH:0]   op_b_shift_q, op_b_shift_d;
  logic [`MD_WIDTH-1:0] numer_q, numer_d;

  logic [`MD_WIDTH:0]   res_adder_l, res_adder_h;
  logic [`MD_WIDTH:0]   op_a_ext, op_b_ext;
  logic [`MD_WIDTH:0]   one_shift;
  logic [`MD_WIDTH:0]   pp, pp_last;
  logic [`MD_WIDTH-1:0] b_0;
  logic [`MD_WIDTH:0]   next_rem, next_quo;
  logic                 sign_a, sign_b;
  logic                 is_ge;
  logic                 div_neg, rem_neg;

  // Plain sum and sum shifted right by one for the high word
  assign res_adder_l = adder_ext_i[`MD_WIDTH:0];
  assign res_adder_h = adder_ext_i[`MD_WIDTH+1:1];

  assign sign_a   = op_a_i[`MD_WIDTH-1] & signed_mode_i[0];
  assign sign_b   = op_b_i[`MD_WIDTH-1] & signed_mode_i[1];
  assign op_a_ext = {sign_a, op_a_i};
  assign op_b_ext = {sign_b, op_b_i};

  // Baugh-Wooley partial products, last one with inverted terms
  assign b_0     = {`MD_WIDTH{op_b_shift_q[0]}};
  assign pp      = {~(op_a_shift_q[`MD_WIDTH] & op_b_shift_q[0]),
                    op_a_shift_q[`MD_WIDTH-1:0] & b_0};
  assign pp_last = {op_a_shift_q[`MD_WIDTH] & op_b_shift_q[0],
                    ~(op_a_shift_q[`MD_WIDTH-1:0] & b_0)};

  // Unsigned compare of partial remainder and divisor
  assign is_ge = ((accum_q[`MD_WIDTH-1] ^ op_b_shift_q[`MD_WIDTH-1]) == 1'b0) ?
                 ~res_adder_h[`MD_WIDTH-1] : accum_q[`MD_WIDTH-1];

  assign one_shift = {{`MD_WIDTH{1'b0}}, 1'b1} << cnt_q;
  assign next_rem  = is_ge ? res_adder_h : accum_q;
  assign next_quo  = is_ge ? (op_a_shift_q | one_shift) : op_a_shift_q;
  assign cnt_m1    = cnt_q - md_pkg::md_cnt_t'(1);

  // Quotient sign from both operands, remainder follows dividend
  assign div_neg = sign_a ^ sign_b;
  assign rem_neg = sign_a;

  assign result_o = div_en_i ? accum_q[`MD_WIDTH-1:0] : res_adder_l[`MD_WIDTH-1:0];

  ////////////////////////////////////////////////////////////
  // Adder operand select
  ////////////////////////////////////////////////////////////
  always_comb begin
    alu_operand_a_o = accum_q;
    alu_operand_b_o = pp;
    case (operator_i)
      md_pkg::MD_OP_MULL: alu_operand_b_o = pp;
      md_pkg::MD_OP_MULH: alu_operand_b_o = (state_q == ST_LAST) ? pp_last : pp;
      default: begin
        case (state_q)
          // Negate B while the zero flag checks for a zero divisor
          ST_IDLE, ST_ABS_B: begin
            alu_operand_a_o = {{`MD_WIDTH{1'b0}}, 1'b1};
            alu_operand_b_o = {~op_b_i, 1'b1};
          end
          ST_ABS_A: begin
            alu_operand_a_o = {{`MD_WIDTH{1'b0}}, 1'b1};
            alu_operand_b_o = {~op_a_i, 1'b1};
          end
          ST_CHSIGN: begin
            alu_operand_a_o = {{`MD_WIDTH{1'b0}}, 1'b1};
            alu_operand_b_o = {~accum_q[`MD_WIDTH-1:0], 1'b1};
          end
          // Trial subtraction of divisor from remainder
          default: begin
            alu_operand_a_o = {accum_q[`MD_WIDTH-1:0], 1'b1};
            alu_operand_b_o = {~op_b_shift_q[`MD_WIDTH-1:0], 1'b1};
          end
        endcase
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Iteration FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    accum_d      = accum_q;
    op_a_shift_d = op_a_shift_q;
    op_b_shift_d = op_b_shift_q;
    numer_d      = numer_q;
    if (mult_en_i || div_en_i) begin
      case (state_q)
        ST_IDLE: begin
          cnt_d = md_pkg::md_cnt_t'(`MD_WIDTH - 1);
          case (operator_i)
            md_pkg::MD_OP_MULL: begin
              op_a_shift_d = op_a_ext << 1;
              accum_d      = {~(op_a_ext[`MD_WIDTH] & op_b_i[0]),
                              op_a_ext[`MD_WIDTH-1:0] & {`MD_WIDTH{op_b_i[0]}}};
              op_b_shift_d = op_b_ext >> 1;
              state_d      = ST_COMP;
            end
            md_pkg::MD_OP_MULH: begin
              op_a_shift_d = op_a_ext;
              accum_d      = {1'b1, ~(op_a_ext[`MD_WIDTH] & op_b_i[0]),
                              op_a_ext[`MD_WIDTH-1:1] & {(`MD_WIDTH-1){op_b_i[0]}}};
              op_b_shift_d = op_b_ext >> 1;
              state_d      = ST_COMP;
            end
            md_pkg::MD_OP_DIV: begin
              // All ones is the quotient for a zero divisor
              accum_d = '1;
              state_d = adder_zero_i ? ST_FINISH : ST_ABS_A;
            end
            default: begin
              // Dividend is the remainder for a zero divisor
              accum_d = op_a_ext;
              state_d = adder_zero_i ? ST_FINISH : ST_ABS_A;
            end
          endcase
        end

        ST_ABS_A: begin
          op_a_shift_d = '0;
          numer_d      = sign_a ? adder_i : op_a_i;
          state_d      = ST_ABS_B;
        end

        ST_ABS_B: begin
          accum_d      = {{`MD_WIDTH{1'b0}}, numer_q[`MD_WIDTH-1]};
          op_b_shift_d = sign_b ? {1'b0, adder_i} : {1'b0, op_b_i};
          state_d      = ST_COMP;
        end

        ST_COMP: begin
          cnt_d = cnt_m1;
          case (operator_i)
            md_pkg::MD_OP_MULL: begin
              accum_d      = res_adder_l;
              op_a_shift_d = op_a_shift_q << 1;
              op_b_shift_d = op_b_shift_q >> 1;
            end
            md_pkg::MD_OP_MULH: begin
              accum_d      = res_adder_h;
              op_b_shift_d = op_b_shift_q >> 1;
            end
            default: begin
              // Shift next numerator bit into the remainder
              accum_d      = {next_rem[`MD_WIDTH-1:0], numer_q[cnt_m1]};
              op_a_shift_d = next_quo;
            end
          endcase
          state_d = (cnt_q == md_pkg::md_cnt_t'(1)) ? ST_LAST : ST_COMP;
        end

        ST_LAST: begin
          case (operator_i)
            md_pkg::MD_OP_MULL, md_pkg::MD_OP_MULH: begin
              accum_d = res_adder_l;
              state_d = ST_IDLE;
            end
            md_pkg::MD_OP_DIV: begin
              accum_d = next_quo;
              state_d = ST_CHSIGN;
            end
            default: begin
              accum_d = {1'b0, next_rem[`MD_WIDTH-1:0]};
              state_d = ST_CHSIGN;
            end
          endcase
        end

        ST_CHSIGN: begin
          state_d = ST_FINISH;
          if (operator_i == md_pkg::MD_OP_DIV) begin
            accum_d = div_neg ? {1'b0, adder_i} : accum_q;
          end else begin
            accum_d = rem_neg ? {1'b0, adder_i} : accum_q;
          end
        end

        ST_FINISH: state_d = ST_IDLE;

        default: state_d = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    accum_q      <= accum_d;
    op_a_shift_q <= op_a_shift_d;
    op_b_shift_q <= op_b_shift_d;
    numer_q      <= numer_d;
  end

  // Multiply finishes in the last iteration and divide one state later
  assign ready_o = (state_q == ST_FINISH) |
                   ((state_q == ST_LAST) &
                    ((operator_i == md_pkg::MD_OP_MULL) |
                     (operator_i == md_pkg::MD_OP_MULH)));

endmodule

//--- verilog/md_unit.sv
////////////////////////////////////////////////////////////
// Multiply/divide unit top level
// Issue stage, iteration core and shared adder
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "md_defines.svh"

module md_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  logic [`MD_FUNCT_WIDTH-1:0] funct_i,
  input  logic [`MD_WIDTH-1:0]      op_a_i,
  input  logic [`MD_WIDTH-1:0]      op_b_i,
  output logic                      busy_o,
  output logic                      done_o,
  output logic [`MD_WIDTH-1:0]      result_o
);

  logic                 mult_en, div_en;
  md_pkg::md_op_e       operator;
  md_pkg::md_sign_t     signed_mode;
  logic [`MD_WIDTH-1:0] md_op_a, md_op_b;
  logic                 md_ready;
  logic [`MD_WIDTH-1:0] md_result;

  // Shared adder path
  logic [`MD_WIDTH:0]   alu_operand_a, alu_operand_b;
  logic [`MD_WIDTH+1:0] adder_ext;
  logic [`MD_WIDTH-1:0] adder_sum;
  logic                 adder_zero;

  md_issue u_md_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .funct_i       (funct_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .mult_en_o     (mult_en),
    .div_en_o      (div_en),
    .operator_o    (operator),
    .signed_mode_o (signed_mode),
    .md_op_a_o     (md_op_a),
    .md_op_b_o     (md_op_b),
    .md_ready_i    (md_ready),
    .md_result_i   (md_result),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .result_o      (result_o)
  );

  md_slow u_md_slow (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mult_en_i       (mult_en),
    .div_en_i        (div_en),
    .operator_i      (operator),
    .signed_mode_i   (signed_mode),
    .op_a_i          (md_op_a),
    .op_b_i          (md_op_b),
    .adder_ext_i     (adder_ext),
    .adder_i         (adder_sum),
    .adder_zero_i    (adder_zero),
    .alu_operand_a_o (alu_operand_a),
    .alu_operand_b_o (alu_operand_b),
    .result_o        (md_result),
    .ready_o         (md_ready)
  );

  md_adder u_md_adder (
    .operand_a_i (alu_operand_a),
    .operand_b_i (alu_operand_b),
    .sum_ext_o   (adder_ext),
    .sum_o       (adder_sum),
    .sum_zero_o  (adder_zero)
  );

endmodule

//--- verif/md_unit_tb.sv
////////////////////////////////////////////////////////////
// Testbench of the multiply/divide unit
// Clock and reset, pattern file stimulus, random cases
// against a reference model, compare tasks and timeouts
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "md_defines.svh"

module md_unit_tb;

  localparam int NUM_PATTERNS = 20;
  localparam int NUM_RANDOM   = 64;
  localparam int WAIT_LIMIT   = 100;
  localparam int QUIET_CYCLES = 45;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 start_i;
  md_pkg::md_funct_t    funct_i;
  logic [`MD_WIDTH-1:0] op_a_i;
  logic [`MD_WIDTH-1:0] op_b_i;
  logic                 busy_o;
  logic                 done_o;
  logic [`MD_WIDTH-1:0] result_o;

  // Four words per pattern in funct, A, B, expected order
  logic [`MD_WIDTH-1:0] pattern_mem [0:4*NUM_PATTERNS-1];
  integer               seed;

  md_unit u_md_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .funct_i  (funct_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .result_o (result_o)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Reference model of the M extension
  ////////////////////////////////////////////////////////////
  function automatic logic [`MD_WIDTH-1:0] expected_result(md_pkg::md_funct_t funct,
      logic [`MD_WIDTH-1:0] a, logic [`MD_WIDTH-1:0] b);
    logic [2*`MD_WIDTH-1:0] a_wide, b_wide, product;
    logic                   a_signed, b_signed, a_neg, b_neg;
    logic [`MD_WIDTH-1:0]   a_mag, b_mag, quo, rem;
    a_signed = (funct == md_pkg::MD_FUNCT_MULH) || (funct == md_pkg::MD_FUNCT_MULHSU) ||
               (funct == md_pkg::MD_FUNCT_DIV) || (funct == md_pkg::MD_FUNCT_REM);
    b_signed = (funct == md_pkg::MD_FUNCT_MULH) || (funct == md_pkg::MD_FUNCT_DIV) ||
               (funct == md_pkg::MD_FUNCT_REM);
    a_wide  = a_signed ? {{`MD_WIDTH{a[`MD_WIDTH-1]}}, a} : {{`MD_WIDTH{1'b0}}, a};
    b_wide  = b_signed ? {{`MD_WIDTH{b[`MD_WIDTH-1]}}, b} : {{`MD_WIDTH{1'b0}}, b};
    product = a_wide * b_wide;
    a_neg   = a_signed & a[`MD_WIDTH-1];
    b_neg   = b_signed & b[`MD_WIDTH-1];
    a_mag   = a_neg ? -a : a;
    b_mag   = b_neg ? -b : b;
    if (b == '0) begin
      quo = '1;
      rem = a;
    end else begin
      // Truncating division where overflow falls out of the magnitudes
      quo = a_mag / b_mag;
      rem = a_mag % b_mag;
      quo = (a_neg ^ b_neg) ? -quo : quo;
      rem = a_neg ? -rem : rem;
    end
    case (funct)
      md_pkg::MD_FUNCT_MUL: return product[`MD_WIDTH-1:0];
      md_pkg::MD_FUNCT_MULH, md_pkg::MD_FUNCT_MULHSU, md_pkg::MD_FUNCT_MULHU:
        return product[2*`MD_WIDTH-1:`MD_WIDTH];
      md_pkg::MD_FUNCT_DIV, md_pkg::MD_FUNCT_DIVU: return quo;
      default: return rem;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_result(string name, logic [`MD_WIDTH-1:0] actual,
                              logic [`MD_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  task automatic check_flag(string name, logic actual, logic expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, actual, expected);
      stop_run();
    end
  endtask

  // Busy holds until the done pulse and drops with it
  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (done_o !== 1'b1) begin
      check_flag("busy_o", busy_o, 1'b1);
      cycles++;
      if (cycles >= WAIT_LIMIT) begin
        $display("Timeout: done_o did not rise within %0d cycles at %0t ns",
                 WAIT_LIMIT, $time);
        stop_run();
      end
      @(negedge clk_i);
    end
    check_flag("busy_o", busy_o, 1'b0);
  endtask

  // One operation with an optional second start while busy
  task automatic run_op(md_pkg::md_funct_t funct, logic [`MD_WIDTH-1:0] a,
                        logic [`MD_WIDTH-1:0] b, logic [`MD_WIDTH-1:0] expected,
                        logic extra_start);
    @(posedge clk_i);
    #2;
    start_i = 1'b1;
    funct_i = funct;
    op_a_i  = a;
    op_b_i  = b;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    check_flag("busy_o", busy_o, 1'b1);
    check_flag("done_o", done_o, 1'b0);
    if (extra_start) begin
      @(posedge clk_i);
      #2;
      start_i = 1'b1;
      funct_i = md_pkg::MD_FUNCT_MUL;
      op_a_i  = ~a;
      op_b_i  = b + 32'd1;
      @(posedge clk_i);
      #2;
      start_i = 1'b0;
    end
    wait_for_done();
    check_result("result_o", result_o, expected);
  endtask

  // No stray done pulse and the result stays put
  task automatic check_quiet(logic [`MD_WIDTH-1:0] held);
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk_i);
      check_flag("done_o", done_o, 1'b0);
      check_flag("busy_o", busy_o, 1'b0);
      check_result("result_o", result_o, held);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    md_pkg::md_funct_t    rnd_funct;
    logic [`MD_WIDTH-1:0] rnd_a, rnd_b;
    int                   pick;
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    start_i = 1'b0;
    funct_i = '0;
    op_a_i  = '0;
    op_b_i  = '0;
    seed    = 32'h295e;
    $readmemh("verif/md_unit_patterns.txt", pattern_mem);

    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("done_o", done_o, 1'b0);
    check_result("result_o", result_o, '0);

    // Directed cases, each started right after the previous done
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      run_op(md_pkg::md_funct_t'(pattern_mem[4*i]), pattern_mem[4*i+1],
             pattern_mem[4*i+2], pattern_mem[4*i+3], 1'b0);
    end

    // Starts while busy are dropped
    run_op(md_pkg::MD_FUNCT_MULHU, 32'hffffffff, 32'hffffffff, 32'hfffffffe, 1'b1);
    check_quiet(32'hfffffffe);
    run_op(md_pkg::MD_FUNCT_DIV, 32'hfffffff9, 32'h00000002, 32'hfffffffd, 1'b1);
    check_quiet(32'hfffffffd);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd_funct = md_pkg::md_funct_t'($random(seed));
      rnd_a     = $random(seed);
      rnd_b     = $random(seed);
      pick      = int'($unsigned($random(seed)) % 8);
      // Bias some draws toward corner operands
      case (pick)
        0: rnd_b = '0;
        1: rnd_b = '1;
        2: rnd_a = 32'h80000000;
        3: rnd_b = rnd_b & 32'h000000ff;
        default: ;
      endcase
      run_op(rnd_funct, rnd_a, rnd_b, expected_result(rnd_funct, rnd_a, rnd_b), 1'b0);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- md_unit.f
+incdir+verilog
verilog/md_pkg.sv
verilog/md_adder.sv
verilog/md_issue.sv
verilog/md_slow.sv
verilog/md_unit.sv
verif/md_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the md_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module md_unit_tb \
  -f md_unit.f -o md_unit_sim

sim_out=$(./obj_dir/md_unit_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

//--- verif/md_unit_patterns.txt
// funct  operand_a  operand_b  expected_result (all hex)
// funct: 0 MUL 1 MULH 2 MULHSU 3 MULHU 4 DIV 5 DIVU 6 REM 7 REMU
0 00000007 00000006 0000002a
0 12345678 00000010 23456780
1 80000000 80000000 40000000
1 ffffffff 00000005 ffffffff
2 ffffffff 00000002 ffffffff
2 00000002 ffffffff 00000001
3 ffffffff ffffffff fffffffe
4 fffffff9 00000002 fffffffd
4 00000007 fffffffe fffffffd
4 fffffff9 fffffffe 00000003
4 80000000 ffffffff 80000000
4 00000064 00000000 ffffffff
5 ffffffff 00000010 0fffffff
5 00000005 00000000 ffffffff
6 fffffff9 00000002 ffffffff
6 00000007 fffffffe 00000001
6 80000000 ffffffff 00000000
6 12345678 00000000 12345678
7 00000064 00000007 00000002
7 9abcdef0 00000000 9abcdef0
